/* compile.f */
common/interconnectPkg.sv
logic/masterArbiter.sv
logic/addressStage.sv
logic/readyReturn.sv
logic/readAddressInterconnect.sv
verification/readAddressInterconnectTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module readAddressInterconnectTb -f compile.f

simStatus=0
./obj_dir/VreadAddressInterconnectTb > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$simStatus" -ne 0 ] || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"

/* verification/readAddressInterconnectTb.sv */
// Reference model assumes one request in flight; masters hold their request until their ready pulse
`timescale 1ns/1ps

module readAddressInterconnectTb;

    localparam int transferTarget = 60;
    localparam int gapStart       = 30;
    localparam int cycleLimit     = 3000;

    logic                                                 clock;
    logic                                                 resetn;
    logic [interconnectPkg::numMasters-1:0]               masterValid;
    interconnectPkg::arPayload [interconnectPkg::numMasters-1:0] masterPayload;
    logic [interconnectPkg::numMasters-1:0]               masterReady;
    logic [interconnectPkg::numSlaves-1:0]                slaveReady;
    logic [interconnectPkg::numSlaves-1:0]                slaveValid;
    interconnectPkg::slavePayload                         slavePayloadOut;

    // Reference model state
    logic                                   modelBusy;
    logic                                   modelOwner;
    logic                                   modelPriority;
    interconnectPkg::slavePayload           expPayload;
    logic [interconnectPkg::numSlaves-1:0]  expSelect;
    logic [interconnectPkg::numMasters-1:0] ownerReady;
    logic                                   slaveTaken;
    logic                                   lastTop;
    int                                     acceptCount;

    // Stimulus state
    logic gapMode;
    int   idleLeft [interconnectPkg::numMasters];
    int   completed [interconnectPkg::numMasters];
    int   stallLeft [interconnectPkg::numSlaves];
    logic stallSeen [interconnectPkg::numSlaves];
    int   errorCount;
    int   runFailures;
    int   cycles;

    readAddressInterconnect u_readAddressInterconnect
    (
        .clock           (clock),
        .resetn          (resetn),
        .masterValid     (masterValid),
        .masterPayload   (masterPayload),
        .masterReady     (masterReady),
        .slaveReady      (slaveReady),
        .slaveValid      (slaveValid),
        .slavePayloadOut (slavePayloadOut)
    );

    always #20 clock = ~clock;

    ////////////////////
    // Helpers
    ////////////////////
    function automatic interconnectPkg::arPayload randomRequest();
        interconnectPkg::arPayload req;
        logic [31:0]               bits;
        req.addr  = $urandom;
        bits      = $urandom;
        req.id    = bits[3:0];
        req.len   = bits[15:8];
        req.size  = bits[18:16];
        req.burst = bits[21:20];
        return req;
    endfunction

    // Master index goes on top of the ID
    function automatic interconnectPkg::slavePayload extendRequest(
        input logic index, input interconnectPkg::arPayload req);
        interconnectPkg::slavePayload ext;
        ext.addr  = req.addr;
        ext.id    = {index, req.id};
        ext.len   = req.len;
        ext.size  = req.size;
        ext.burst = req.burst;
        return ext;
    endfunction

    function automatic logic pickWinner(
        input logic [interconnectPkg::numMasters-1:0] pend, input logic prio);
        if (pend[prio])
        begin
            return prio;
        end
        else
        begin
            return !prio;
        end
    endfunction

    task automatic driveMasters();
        for (int m = 0; m < interconnectPkg::numMasters; m++)
        begin
            if (masterReady[m])
            begin
                completed[m]++;
                if (gapMode && ($urandom_range(0, 1) == 1))
                begin
                    masterValid[m] = 1'b0;
                    idleLeft[m]    = $urandom_range(1, 3);
                end
                else
                begin
                    masterPayload[m] = randomRequest();
                end
            end
            else if (!masterValid[m])
            begin
                if (idleLeft[m] > 0)
                begin
                    idleLeft[m]--;
                end
                else
                begin
                    masterValid[m]   = 1'b1;
                    masterPayload[m] = randomRequest();
                end
            end
        end
    endtask

    // Each slave stalls 0 to 3 cycles on a new request
    task automatic driveSlaves();
        for (int s = 0; s < interconnectPkg::numSlaves; s++)
        begin
            if (!slaveValid[s])
            begin
                slaveReady[s] = 1'b0;
                stallSeen[s]  = 1'b0;
            end
            else if (!stallSeen[s])
            begin
                stallSeen[s]  = 1'b1;
                stallLeft[s]  = $urandom_range(0, 3);
                slaveReady[s] = (stallLeft[s] == 0);
            end
            else if (stallLeft[s] > 0)
            begin
                stallLeft[s]--;
                slaveReady[s] = (stallLeft[s] == 0);
            end
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    assign slaveTaken = |(slaveValid & slaveReady);

    always_comb
    begin
        expSelect = '0;
        expSelect[expPayload.addr[interconnectPkg::addrWidth-1 -:
                                  interconnectPkg::slaveSelWidth]] = 1'b1;
        ownerReady = '0;
        ownerReady[modelOwner] = 1'b1;
    end

    always @(posedge clock or negedge resetn)
    begin : referenceModel
        logic winner;
        if (!resetn)
        begin
            modelBusy     <= 1'b0;
            modelOwner    <= 1'b0;
            modelPriority <= 1'b0;
            expPayload    <= '0;
            lastTop       <= 1'b1;
            acceptCount   <= 0;
        end
        else if (!modelBusy)
        begin
            if (|(masterValid & ~masterReady))
            begin
                winner     = pickWinner(masterValid & ~masterReady, modelPriority);
                modelBusy  <= 1'b1;
                modelOwner <= winner;
                expPayload <= extendRequest(winner, masterPayload[winner]);
            end
        end
        else if (slaveTaken)
        begin
            modelBusy     <= 1'b0;
            modelPriority <= !modelOwner;
            lastTop       <= modelOwner;
            acceptCount   <= acceptCount + 1;
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    resetQuiet: assert property (@(posedge clock)
        (!resetn || $rose(resetn)) |->
            (slaveValid == '0 && masterReady == '0 && slavePayloadOut == '0))
    else
    begin
        errorCount++;
        $display("mismatch reset outputs slaveValid %h masterReady %h slavePayloadOut %h",
                 $sampled(slaveValid), $sampled(masterReady), $sampled(slavePayloadOut));
    end

    routePayload: assert property (@(posedge clock) disable iff (!resetn)
        (slaveValid != '0) |-> (slavePayloadOut == expPayload))
    else
    begin
        errorCount++;
        $display("mismatch slavePayloadOut got %h expected %h",
                 $sampled(slavePayloadOut), $sampled(expPayload));
    end

    routeSelect: assert property (@(posedge clock) disable iff (!resetn)
        (slaveValid != '0) |-> (slaveValid == expSelect))
    else
    begin
        errorCount++;
        $display("mismatch slaveValid got %h expected %h",
                 $sampled(slaveValid), $sampled(expSelect));
    end

    // Bus reads zero while nothing is offered
    idlePayload: assert property (@(posedge clock) disable iff (!resetn)
        (slaveValid == '0) |-> (slavePayloadOut == '0))
    else
    begin
        errorCount++;
        $display("mismatch slavePayloadOut got %h expected %h", $sampled(slavePayloadOut), 0);
    end

    stallHold: assert property (@(posedge clock) disable iff (!resetn)
        (|(slaveValid & ~slaveReady)) |=>
            ($stable(slaveValid) && $stable(slavePayloadOut) && masterReady == '0))
    else
    begin
        errorCount++;
        $display("mismatch slavePayloadOut got %h expected %h, slaveValid %h masterReady %h",
                 $sampled(slavePayloadOut), $sampled(expPayload),
                 $sampled(slaveValid), $sampled(masterReady));
    end

    completeReady: assert property (@(posedge clock) disable iff (!resetn)
        slaveTaken |=> (masterReady == ownerReady))
    else
    begin
        errorCount++;
        $display("mismatch masterReady got %h expected %h",
                 $sampled(masterReady), $sampled(ownerReady));
    end

    completeClear: assert property (@(posedge clock) disable iff (!resetn)
        slaveTaken |=> (slaveValid == '0))
    else
    begin
        errorCount++;
        $display("mismatch slaveValid got %h expected %h", $sampled(slaveValid), 0);
    end

    readyPulse: assert property (@(posedge clock) disable iff (!resetn)
        (|masterReady) |-> $past(slaveTaken) ##1 (masterReady == '0))
    else
    begin
        errorCount++;
        $display("mismatch masterReady got %h, pulse not one cycle after acceptance",
                 $sampled(masterReady));
    end

    firstWinner: assert property (@(posedge clock) disable iff (!resetn)
        (slaveTaken && acceptCount == 0) |->
            (slavePayloadOut.id[interconnectPkg::slaveIdWidth-1] == 1'b0))
    else
    begin
        errorCount++;
        $display("mismatch first winner got %h expected %h",
                 $sampled(slavePayloadOut.id[interconnectPkg::slaveIdWidth-1]), 0);
    end

    // Both masters keep requesting until gaps begin
    alternation: assert property (@(posedge clock) disable iff (!resetn)
        (slaveTaken && !gapMode && acceptCount > 0) |->
            (slavePayloadOut.id[interconnectPkg::slaveIdWidth-1] != lastTop))
    else
    begin
        errorCount++;
        $display("mismatch winner index got %h expected %h",
                 $sampled(slavePayloadOut.id[interconnectPkg::slaveIdWidth-1]), !lastTop);
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        void'($urandom(86));
        clock         = 1'b0;
        resetn        = 1'b1;
        masterValid   = '0;
        masterPayload = '0;
        slaveReady    = '0;
        gapMode       = 1'b0;
        errorCount    = 0;
        runFailures   = 0;
        cycles        = 0;
        for (int m = 0; m < interconnectPkg::numMasters; m++)
        begin
            idleLeft[m]  = 0;
            completed[m] = 0;
        end
        for (int s = 0; s < interconnectPkg::numSlaves; s++)
        begin
            stallLeft[s] = 0;
            stallSeen[s] = 1'b0;
        end
        #1 resetn = 1'b0;
        repeat (4) @(posedge clock);
        #1 resetn = 1'b1;

        // Run until enough transfers complete, bounded by cycleLimit
        while ((completed[0] + completed[1]) < transferTarget && cycles < cycleLimit)
        begin
            @(posedge clock);
            #1;
            if ((completed[0] + completed[1]) >= gapStart)
            begin
                gapMode = 1'b1;
            end
            driveMasters();
            driveSlaves();
            cycles++;
        end
        if ((completed[0] + completed[1]) < transferTarget)
        begin
            runFailures++;
            $display("timeout: only %0d transfers finished in %0d cycles",
                     completed[0] + completed[1], cycles);
        end
        if (completed[0] == 0 || completed[1] == 0)
        begin
            runFailures++;
            $display("a master never received a ready pulse");
        end
        repeat (2) @(posedge clock);
        $display("transfers m0 %0d m1 %0d, assertion errors %0d, other failures %0d",
                 completed[0], completed[1], errorCount, runFailures);
        if (errorCount == 0 && runFailures == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* logic/readAddressInterconnect.sv */
// Read address channel only; two masters, four slaves on one shared payload bus
`timescale 1ns/1ps

module readAddressInterconnect
(
    input  logic                                                 clock,
    input  logic                                                 resetn,
    input  logic [interconnectPkg::numMasters-1:0]               masterValid,
    input  interconnectPkg::arPayload [interconnectPkg::numMasters-1:0] masterPayload,
    output logic [interconnectPkg::numMasters-1:0]               masterReady,
    input  logic [interconnectPkg::numSlaves-1:0]                slaveReady,
    output logic [interconnectPkg::numSlaves-1:0]                slaveValid,
    output interconnectPkg::slavePayload                         slavePayloadOut
);

    logic                         grant;
    logic                         grantIndex;
    logic                         accepted;
    interconnectPkg::slavePayload grantedPayload;

    ////////////////////
    // Input side
    ////////////////////
    masterArbiter u_masterArbiter
    (
        .clock          (clock),
        .resetn         (resetn),
        .masterValid    (masterValid),
        .masterPayload  (masterPayload),
        .masterReady    (masterReady),
        .accepted       (accepted),
        .grant          (grant),
        .grantIndex     (grantIndex),
        .grantedPayload (grantedPayload)
    );

    ////////////////////
    // Capture and decode
    ////////////////////
    addressStage u_addressStage
    (
        .clock           (clock),
        .resetn          (resetn),
        .grant           (grant),
        .grantedPayload  (grantedPayload),
        .slaveReady      (slaveReady),
        .slaveValid      (slaveValid),
        .slavePayloadOut (slavePayloadOut),
        .accepted        (accepted)
    );

    ////////////////////
    // Output side
    ////////////////////
    readyReturn u_readyReturn
    (
        .clock       (clock),
        .resetn      (resetn),
        .grant       (grant),
        .grantIndex  (grantIndex),
        .accepted    (accepted),
        .masterReady (masterReady)
    );

endmodule

/* logic/readyReturn.sv */
// Master ready is a single-cycle pulse one clock after acceptance, never a level
`timescale 1ns/1ps

module readyReturn
(
    input  logic                                   clock,
    input  logic                                   resetn,
    input  logic                                   grant,
    input  logic                                   grantIndex,
    input  logic                                   accepted,
    output logic [interconnectPkg::numMasters-1:0] masterReady
);

    logic owner;

    ////////////////////
    // Owner of the request in flight
    ////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            owner <= 1'b0;
        end
        else if (grant)
        begin
            owner <= grantIndex;
        end
    end

    ////////////////////
    // Ready pulse
    ////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            masterReady <= '0;
        end
        else
        begin
            masterReady <= '0;
            if (accepted)
            begin
                masterReady[owner] <= 1'b1;
            end
        end
    end

    // A master is never granted again while its ready is up
    assert property (@(posedge clock) disable iff (!resetn)
        grant |-> !masterReady[grantIndex]);

endmodule

/* logic/addressStage.sv */
// Assumes grant never arrives while a request is held; payload reads zero whenever no slave valid
`timescale 1ns/1ps

module addressStage
(
    input  logic                                  clock,
    input  logic                                  resetn,
    input  logic                                  grant,
    input  interconnectPkg::slavePayload          grantedPayload,
    input  logic [interconnectPkg::numSlaves-1:0] slaveReady,
    output logic [interconnectPkg::numSlaves-1:0] slaveValid,
    output interconnectPkg::slavePayload          slavePayloadOut,
    output logic                                  accepted
);

    logic [interconnectPkg::slaveSelWidth-1:0] grantSel;
    logic [interconnectPkg::slaveSelWidth-1:0] heldSel;
    logic [interconnectPkg::numSlaves-1:0]     grantDecode;
    logic [interconnectPkg::numSlaves-1:0]     heldDecode;

    ////////////////////
    // Address decode
    ////////////////////

    // Address space split evenly by the top bits
    assign grantSel = grantedPayload.addr[interconnectPkg::addrWidth-1 -:
                                          interconnectPkg::slaveSelWidth];
    assign heldSel  = slavePayloadOut.addr[interconnectPkg::addrWidth-1 -:
                                           interconnectPkg::slaveSelWidth];

    always_comb
    begin
        grantDecode           = '0;
        grantDecode[grantSel] = 1'b1;
        heldDecode            = '0;
        heldDecode[heldSel]   = 1'b1;
    end

    // Handshake on the addressed slave only
    assign accepted = slaveValid[heldSel] & slaveReady[heldSel];

    ////////////////////
    // Slave valids
    ////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            slaveValid <= '0;
        end
        else if (accepted)
        begin
            slaveValid <= slaveValid & ~heldDecode;
        end
        else if (grant)
        begin
            slaveValid <= grantDecode;
        end
    end

    ////////////////////
    // Payload capture
    ////////////////////

    // Held under back-pressure, zeroed once taken
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            slavePayloadOut <= '0;
        end
        else if (accepted)
        begin
            slavePayloadOut <= '0;
        end
        else if (grant)
        begin
            slavePayloadOut <= grantedPayload;
        end
    end

    // A new grant never lands on a request still held
    assert property (@(posedge clock) disable iff (!resetn)
        grant |-> (slaveValid == '0));

    // Stalled request stays put until the slave takes it
    assert property (@(posedge clock) disable iff (!resetn)
        (|(slaveValid & ~slaveReady)) |=> $stable(slaveValid) && $stable(slavePayloadOut));

endmodule

/* logic/masterArbiter.sv */
// Grant is combinational and only issued while idle; one request in flight until accepted
`timescale 1ns/1ps

module masterArbiter
(
    input  logic                                                 clock,
    input  logic                                                 resetn,
    input  logic [interconnectPkg::numMasters-1:0]               masterValid,
    input  interconnectPkg::arPayload [interconnectPkg::numMasters-1:0] masterPayload,
    input  logic [interconnectPkg::numMasters-1:0]               masterReady,
    input  logic                                                 accepted,
    output logic                                                 grant,
    output logic                                                 grantIndex,
    output interconnectPkg::slavePayload                         grantedPayload
);

    interconnectPkg::arbState                     state;
    interconnectPkg::arbState                     nextState;
    logic [interconnectPkg::numMasters-1:0]       pending;
    interconnectPkg::arPayload                    selected;

    // A master whose ready is up this cycle was just served
    assign pending = masterValid & ~masterReady;

    ////////////////////
    // State register
    ////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= interconnectPkg::m0PriorityIdle;
        end
        else
        begin
            state <= nextState;
        end
    end

    ////////////////////
    // Round robin choice
    ////////////////////
    always_comb
    begin
        nextState  = state;
        grant      = 1'b0;
        grantIndex = 1'b0;
        case (state)
            interconnectPkg::m0PriorityIdle:
            begin
                if (pending[0])
                begin
                    grant      = 1'b1;
                    grantIndex = 1'b0;
                    nextState  = interconnectPkg::m0WaitAccept;
                end
                else if (pending[1])
                begin
                    grant      = 1'b1;
                    grantIndex = 1'b1;
                    nextState  = interconnectPkg::m1WaitAccept;
                end
            end
            interconnectPkg::m1PriorityIdle:
            begin
                if (pending[1])
                begin
                    grant      = 1'b1;
                    grantIndex = 1'b1;
                    nextState  = interconnectPkg::m1WaitAccept;
                end
                else if (pending[0])
                begin
                    grant      = 1'b1;
                    grantIndex = 1'b0;
                    nextState  = interconnectPkg::m0WaitAccept;
                end
            end
            // Priority passes to the other master once accepted
            interconnectPkg::m0WaitAccept:
            begin
                if (accepted)
                begin
                    nextState = interconnectPkg::m1PriorityIdle;
                end
            end
            interconnectPkg::m1WaitAccept:
            begin
                if (accepted)
                begin
                    nextState = interconnectPkg::m0PriorityIdle;
                end
            end
        endcase
    end

    ////////////////////
    // Request mux
    ////////////////////
    assign selected = masterPayload[grantIndex];

    always_comb
    begin
        grantedPayload.addr  = selected.addr;
        grantedPayload.id    = {grantIndex, selected.id};
        grantedPayload.len   = selected.len;
        grantedPayload.size  = selected.size;
        grantedPayload.burst = selected.burst;
    end

    // Acceptance only answers a request that is in flight
    assert property (@(posedge clock) disable iff (!resetn)
        accepted |-> (state == interconnectPkg::m0WaitAccept ||
                      state == interconnectPkg::m1WaitAccept));

endmodule

/* common/interconnectPkg.sv */
// Widths are fixed here; two masters and four slaves only, and slave selection uses top address bits
package interconnectPkg;

    ////////////////////
    // Widths and counts
    ////////////////////
    localparam int addrWidth     = 32;
    localparam int idWidth       = 4;
    localparam int lenWidth      = 8;
    localparam int sizeWidth     = 3;
    localparam int burstWidth    = 2;
    localparam int numMasters    = 2;
    localparam int numSlaves     = 4;
    localparam int slaveSelWidth = 2;

    // Slave side ID carries the master index as its top bit
    localparam int slaveIdWidth  = idWidth + 1;

    ////////////////////
    // Payloads
    ////////////////////

    // Read address request as a master presents it
    typedef struct packed {
        logic [addrWidth-1:0]  addr;
        logic [idWidth-1:0]    id;
        logic [lenWidth-1:0]   len;
        logic [sizeWidth-1:0]  size;
        logic [burstWidth-1:0] burst;
    } arPayload;

    // Request as broadcast on the shared slave bus
    typedef struct packed {
        logic [addrWidth-1:0]    addr;
        logic [slaveIdWidth-1:0] id;
        logic [lenWidth-1:0]     len;
        logic [sizeWidth-1:0]    size;
        logic [burstWidth-1:0]   burst;
    } slavePayload;

    ////////////////////
    // Arbiter states
    ////////////////////
    typedef enum logic [1:0] {
        m0PriorityIdle = 2'd0,
        m1PriorityIdle = 2'd1,
        m0WaitAccept   = 2'd2,
        m1WaitAccept   = 2'd3
    } arbState;

endpackage
